// File: Makefile
# Verilator build, run and lint for the data-memory slave.
# A failing run ends in $fatal, so the run target fails with it.

VERILATOR  ?= verilator
TOP        ?= tb_lsu
RTL_TOP    ?= lsu_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
BUILD_ARGS ?= --binary --timing --assert -Wno-fatal
LINT_ARGS  ?= --lint-only -Wall --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_ARGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_ARGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
logic/lsu_pkg.sv
logic/lsu_ctrl.sv
logic/store_align.sv
logic/data_mem.sv
logic/load_extract.sv
logic/lsu_top.sv
testbench/tb_lsu.sv

// File: logic/data_mem.sv
/*
  data_mem
  Word-organised data memory with access to two adjacent words at once.
  Writes are byte-enabled on both words, reads register both words.
*/
`timescale 1ns/10ps

module data_mem
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic [WORD_IDX_W-1:0] i_word_idx,
  input  logic                  i_we,
  input  logic                  i_re,
  input  logic [3:0]            i_lo_be,
  input  logic [3:0]            i_hi_be,
  input  logic [DATA_W-1:0]     i_lo_data,
  input  logic [DATA_W-1:0]     i_hi_data,
  output logic [DATA_W-1:0]     o_lo_word,
  output logic [DATA_W-1:0]     o_hi_word
);

  logic [DATA_W-1:0]     mem [MEM_WORDS];
  logic [WORD_IDX_W-1:0] next_idx;

  // the word after the last one is word 0.
  assign next_idx = i_word_idx + WORD_IDX_W'(1);

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int b = 0; b < 4; b++) begin
        if (i_lo_be[b]) mem[i_word_idx][8*b +: 8] <= i_lo_data[8*b +: 8];
        if (i_hi_be[b]) mem[next_idx][8*b +: 8]   <= i_hi_data[8*b +: 8];
      end
    end
  end

  // outputs hold their value between reads.
  always_ff @(posedge i_clk) begin
    if (i_re) begin
      o_lo_word <= mem[i_word_idx];
      o_hi_word <= mem[next_idx];
    end
  end

endmodule

// File: logic/load_extract.sv
/*
  load_extract
  Picks the loaded bytes out of two adjacent memory words and extends
  them to 32 bits, with sign or zero fill depending on the funct3 code.
*/
`timescale 1ns/10ps

module load_extract
  import lsu_pkg::*;
(
  input  logic [DATA_W-1:0] i_lo_word,
  input  logic [DATA_W-1:0] i_hi_word,
  input  logic [1:0]        i_offset,
  input  access_size_e      i_size,
  output logic [DATA_W-1:0] o_rdata
);

  logic [5:0]        bit_shift;
  logic [DATA_W-1:0] window;

  assign bit_shift = {1'b0, i_offset, 3'b000};

  // after the shift the first addressed byte sits in bits 7:0.
  assign window = DATA_W'({i_hi_word, i_lo_word} >> bit_shift);

  always_comb begin
    case (i_size)
      SZ_B:    o_rdata = {{24{window[7]}}, window[7:0]};
      SZ_H:    o_rdata = {{16{window[15]}}, window[15:0]};
      SZ_W:    o_rdata = window;
      SZ_BU:   o_rdata = {24'b0, window[7:0]};
      SZ_HU:   o_rdata = {16'b0, window[15:0]};
      default: o_rdata = '0;                    // reserved codes never read memory.
    endcase
  end

endmodule

// File: logic/lsu_ctrl.sv
/*
  lsu_ctrl
  Wishbone classic slave controller. Latches one request, checks that the
  size tag is legal for the direction, pulses the memory strobe and answers
  with ack, or with err straight from idle for an illegal request.
*/
`timescale 1ns/10ps

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  logic [ADDR_W-1:0]     i_wb_adr,
  input  logic [DATA_W-1:0]     i_wb_dat,
  input  logic [2:0]            i_wb_tga,
  output logic                  o_wb_ack,
  output logic                  o_wb_err,
  output logic [WORD_IDX_W-1:0] o_word_idx,
  output logic [1:0]            o_offset,
  output access_size_e          o_size,
  output logic [DATA_W-1:0]     o_wdata,
  output logic                  o_mem_we,
  output logic                  o_mem_re
);

  lsu_state_e        state;
  logic [ADDR_W-1:0] adr_q;
  logic [DATA_W-1:0] dat_q;
  access_size_e      size_q;
  logic              we_q;
  logic              req;
  logic              legal;

  assign req = i_wb_cyc && i_wb_stb;

  // unsigned sizes make no sense on a store.
  always_comb begin
    case (access_size_e'(i_wb_tga))
      SZ_B, SZ_H, SZ_W: legal = 1'b1;
      SZ_BU, SZ_HU:     legal = ~i_wb_we;
      default:          legal = 1'b0;
    endcase
  end

  // the request is held here until the next one, so load extraction still
  // sees the right offset and size during the ack cycle.
  always_ff @(posedge i_clk) begin
    if ((state == ST_IDLE) && req) begin
      adr_q  <= i_wb_adr;
      dat_q  <= i_wb_dat;
      size_q <= access_size_e'(i_wb_tga);
      we_q   <= i_wb_we;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      state    <= ST_IDLE;
      o_wb_ack <= 1'b0;
      o_wb_err <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            if (legal) begin
              state <= ST_ACCESS;
            end else begin
              state    <= ST_ACK;                // memory is left alone.
              o_wb_err <= 1'b1;
            end
          end
        end
        ST_ACCESS: begin
          state    <= ST_ACK;
          o_wb_ack <= 1'b1;                      // memory acts on this same edge.
        end
        ST_ACK: begin
          state    <= ST_IDLE;
          o_wb_ack <= 1'b0;
          o_wb_err <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign o_mem_we = (state == ST_ACCESS) && we_q;
  assign o_mem_re = (state == ST_ACCESS) && !we_q;

  assign o_word_idx = adr_q[ADDR_W-1:2];
  assign o_offset   = adr_q[1:0];
  assign o_size     = size_q;
  assign o_wdata    = dat_q;

endmodule

// File: logic/lsu_pkg.sv
/*
  lsu_pkg
  Shared sizes and types for the RISC-V data-memory slave. The access size
  codes follow the RISC-V funct3 encoding of the load and store opcodes.
*/
package lsu_pkg;

  // byte address of 14 bits gives 16 KiB of data memory.
  localparam int ADDR_W     = 14;
  localparam int DATA_W     = 32;
  localparam int WORD_IDX_W = 12;              // ADDR_W minus the two byte offset bits.
  localparam int MEM_WORDS  = 4096;

  // funct3 codes carried on the Wishbone address tag.
  // 011, 110 and 111 are reserved and answered with an error.
  typedef enum logic [2:0] {
    SZ_B  = 3'b000,                            // signed byte.
    SZ_H  = 3'b001,                            // signed halfword.
    SZ_W  = 3'b010,
    SZ_BU = 3'b100,                            // unsigned byte, loads only.
    SZ_HU = 3'b101                             // unsigned halfword, loads only.
  } access_size_e;

  // request sequencing in the controller.
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_ACCESS = 2'b01,
    ST_ACK    = 2'b10
  } lsu_state_e;

endpackage

// File: logic/lsu_top.sv
/*
  lsu_top
  Data-memory slave for a RISC-V core behind a Wishbone classic port.
  Joins the controller with the store aligner, the memory and the load
  extractor.
*/
`timescale 1ns/10ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  logic [ADDR_W-1:0] i_wb_adr,
  input  logic [DATA_W-1:0] i_wb_dat,
  input  logic [2:0]        i_wb_tga,
  output logic [DATA_W-1:0] o_wb_dat,
  output logic              o_wb_ack,
  output logic              o_wb_err
);

  logic [WORD_IDX_W-1:0] word_idx;
  logic [1:0]            offset;
  access_size_e          size;
  logic [DATA_W-1:0]     wdata;
  logic                  mem_we;
  logic                  mem_re;
  logic [3:0]            lo_be;
  logic [3:0]            hi_be;
  logic [DATA_W-1:0]     lo_data;
  logic [DATA_W-1:0]     hi_data;
  logic [DATA_W-1:0]     lo_word;
  logic [DATA_W-1:0]     hi_word;

  lsu_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .i_wb_tga   (i_wb_tga),
    .o_wb_ack   (o_wb_ack),
    .o_wb_err   (o_wb_err),
    .o_word_idx (word_idx),
    .o_offset   (offset),
    .o_size     (size),
    .o_wdata    (wdata),
    .o_mem_we   (mem_we),
    .o_mem_re   (mem_re)
  );

  store_align u_store_align (
    .i_offset  (offset),
    .i_size    (size),
    .i_wdata   (wdata),
    .o_lo_be   (lo_be),
    .o_hi_be   (hi_be),
    .o_lo_data (lo_data),
    .o_hi_data (hi_data)
  );

  data_mem u_data_mem (
    .i_clk      (i_clk),
    .i_word_idx (word_idx),
    .i_we       (mem_we),
    .i_re       (mem_re),
    .i_lo_be    (lo_be),
    .i_hi_be    (hi_be),
    .i_lo_data  (lo_data),
    .i_hi_data  (hi_data),
    .o_lo_word  (lo_word),
    .o_hi_word  (hi_word)
  );

  load_extract u_load_extract (
    .i_lo_word (lo_word),
    .i_hi_word (hi_word),
    .i_offset  (offset),
    .i_size    (size),
    .o_rdata   (o_wb_dat)
  );

endmodule

// File: logic/store_align.sv
/*
  store_align
  Places store data on the byte lanes of two adjacent memory words. The
  low word is the addressed one, the high word takes whatever spills over
  past its last byte.
*/
`timescale 1ns/10ps

module store_align
  import lsu_pkg::*;
(
  input  logic [1:0]        i_offset,
  input  access_size_e      i_size,
  input  logic [DATA_W-1:0] i_wdata,
  output logic [3:0]        o_lo_be,
  output logic [3:0]        o_hi_be,
  output logic [DATA_W-1:0] o_lo_data,
  output logic [DATA_W-1:0] o_hi_data
);

  logic [3:0]          mask;
  logic [7:0]          be_wide;
  logic [2*DATA_W-1:0] data_wide;
  logic [5:0]          bit_shift;

  // byte mask before shifting, one bit per stored byte.
  always_comb begin
    case (i_size)
      SZ_B, SZ_BU: mask = 4'b0001;
      SZ_H, SZ_HU: mask = 4'b0011;
      SZ_W:        mask = 4'b1111;
      default:     mask = 4'b0000;
    endcase
  end

  assign bit_shift = {1'b0, i_offset, 3'b000};  // offset in bytes, times eight.

  assign be_wide   = {4'b0000, mask} << i_offset;
  assign data_wide = {{DATA_W{1'b0}}, i_wdata} << bit_shift;

  // Lanes outside the mask carry shifted garbage; the enables keep them out.
  assign o_lo_be   = be_wide[3:0];
  assign o_hi_be   = be_wide[7:4];
  assign o_lo_data = data_wide[DATA_W-1:0];
  assign o_hi_data = data_wide[2*DATA_W-1:DATA_W];

endmodule

// File: testbench/tb_lsu.sv
/*
  tb_lsu
  Directed testbench for the Wishbone data-memory slave. Keeps a byte-wide
  reference model of the memory and checks every load against it.
*/
`timescale 1ns/10ps

module tb_lsu
  import lsu_pkg::*;
;

  localparam int RESP_TIMEOUT = 16;

  logic              i_clk;
  logic              i_reset;
  logic              i_wb_cyc;
  logic              i_wb_stb;
  logic              i_wb_we;
  logic [ADDR_W-1:0] i_wb_adr;
  logic [DATA_W-1:0] i_wb_dat;
  logic [2:0]        i_wb_tga;
  logic [DATA_W-1:0] o_wb_dat;
  logic              o_wb_ack;
  logic              o_wb_err;

  logic [7:0] model_mem [1 << ADDR_W];  // one entry per byte address.

  lsu_top uut (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .i_wb_tga (i_wb_tga),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack),
    .o_wb_err (o_wb_err)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      fail_run($sformatf("** Error at %0t ns: %s expected %h, got %h",
                         $time, name, expected, actual));
  endtask

  // number of bytes moved for a funct3 code.
  function automatic int size_bytes(input logic [2:0] f3);
    return 1 << f3[1:0];
  endfunction

  function automatic void model_store(input logic [ADDR_W-1:0] addr, input logic [2:0] f3,
                                      input logic [31:0] data);
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < size_bytes(f3); i++) begin
      a = addr + ADDR_W'(i);              // wraps at the top of memory.
      model_mem[a] = data[8*i +: 8];
    end
  endfunction

  function automatic logic [31:0] model_load(input logic [ADDR_W-1:0] addr,
                                             input logic [2:0] f3);
    logic [ADDR_W-1:0] a;
    logic [31:0]       raw;
    int                n;
    raw = '0;
    n = size_bytes(f3);
    for (int i = 0; i < n; i++) begin
      a = addr + ADDR_W'(i);
      raw[8*i +: 8] = model_mem[a];
    end
    if (!f3[2] && (n == 1)) raw = {{24{raw[7]}}, raw[7:0]};
    else if (!f3[2] && (n == 2)) raw = {{16{raw[15]}}, raw[15:0]};
    return raw;
  endfunction

  // one Wishbone classic cycle, entered and left on a falling edge.
  task automatic wb_cycle(input logic we, input logic [ADDR_W-1:0] addr, input logic [2:0] tga,
                          input logic [31:0] data, output int lat, output logic got_ack,
                          output logic got_err, output logic [31:0] rdata);
    lat = 0;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = addr;
    i_wb_dat = data;
    i_wb_tga = tga;
    do begin
      @(negedge i_clk);
      lat++;
    end while (!o_wb_ack && !o_wb_err && (lat < RESP_TIMEOUT));
    got_ack = o_wb_ack;
    got_err = o_wb_err;
    rdata   = o_wb_dat;
    assert (got_ack || got_err) else
      fail_run($sformatf("no ack or err within %0d cycles for address %h", RESP_TIMEOUT, addr));
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    @(negedge i_clk);
    assert (!o_wb_ack && !o_wb_err) else
      fail_run($sformatf("response to address %h lasted more than one cycle", addr));
  endtask

  task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [2:0] f3,
                          input logic [31:0] data);
    int          lat;
    logic        got_ack;
    logic        got_err;
    logic [31:0] rdata;
    wb_cycle(1'b1, addr, f3, data, lat, got_ack, got_err, rdata);
    check_value("o_wb_err", 32'd0, {31'b0, got_err});
    check_value("o_wb_ack latency", 32'd2, lat);
    model_store(addr, f3, data);
  endtask

  task automatic wb_read(input logic [ADDR_W-1:0] addr, input logic [2:0] f3,
                         output logic [31:0] rdata);
    int   lat;
    logic got_ack;
    logic got_err;
    wb_cycle(1'b0, addr, f3, 32'h0, lat, got_ack, got_err, rdata);
    check_value("o_wb_err", 32'd0, {31'b0, got_err});
    check_value("o_wb_ack latency", 32'd2, lat);
  endtask

  task automatic load_check(input logic [ADDR_W-1:0] addr, input logic [2:0] f3);
    logic [31:0] rdata;
    wb_read(addr, f3, rdata);
    check_value($sformatf("o_wb_dat (addr %h, f3 %b)", addr, f3), model_load(addr, f3), rdata);
  endtask

  task automatic err_check(input logic we, input logic [ADDR_W-1:0] addr, input logic [2:0] tga);
    int          lat;
    logic        got_ack;
    logic        got_err;
    logic [31:0] rdata;
    wb_cycle(we, addr, tga, 32'hffff_ffff, lat, got_ack, got_err, rdata);
    check_value("o_wb_ack", 32'd0, {31'b0, got_ack});
    check_value("o_wb_err", 32'd1, {31'b0, got_err});
    check_value("o_wb_err latency", 32'd1, lat);
  endtask

  task automatic words_after_reset();
    logic [ADDR_W-1:0] a;
    check_value("o_wb_ack", 32'd0, {31'b0, o_wb_ack});
    check_value("o_wb_err", 32'd0, {31'b0, o_wb_err});
    for (int i = 0; i < 5; i++) begin
      a = ADDR_W'(i * 3276) & 14'h3ffc;
      wb_write(a, SZ_W, $urandom);
    end
    for (int i = 0; i < 5; i++) begin
      a = ADDR_W'(i * 3276) & 14'h3ffc;
      load_check(a, SZ_W);
    end
  endtask

  task automatic subword_merge();
    logic [ADDR_W-1:0] base;
    base = 14'h0040;
    // the upper data bytes are junk and must not reach memory.
    for (int off = 0; off < 4; off++) begin
      wb_write(base, SZ_W, 32'h1122_3344);
      wb_write(base + ADDR_W'(off), SZ_B, 32'hffff_ffa0 + 32'(off));
      load_check(base, SZ_W);
    end
    for (int off = 0; off < 4; off++) begin
      wb_write(base, SZ_W, 32'h5566_7788);
      wb_write(base + 14'd4, SZ_W, 32'h99aa_bbcc);
      wb_write(base + ADDR_W'(off), SZ_H, 32'hdead_c0d0 + 32'(off));
      load_check(base, SZ_W);
      load_check(base + 14'd4, SZ_W);
    end
  endtask

  task automatic load_extension();
    logic [ADDR_W-1:0] base;
    base = 14'h0080;
    wb_write(base, SZ_W, 32'h80f1_92e3);  // every byte has its top bit set.
    wb_write(base + 14'd4, SZ_W, 32'h7f01_8c45);
    for (int off = 0; off < 4; off++) begin
      load_check(base + ADDR_W'(off), SZ_B);
      load_check(base + ADDR_W'(off), SZ_BU);
      load_check(base + ADDR_W'(off), SZ_H);
      load_check(base + ADDR_W'(off), SZ_HU);
    end
  endtask

  task automatic misaligned_access();
    logic [ADDR_W-1:0] base;
    base = 14'h0200;
    wb_write(base, SZ_W, 32'h0102_0304);
    wb_write(base + 14'd4, SZ_W, 32'h0506_0708);
    wb_write(base + 14'd8, SZ_W, 32'h090a_0b0c);
    for (int off = 1; off < 4; off++) begin
      wb_write(base + ADDR_W'(off), SZ_W, $urandom);
      load_check(base + ADDR_W'(off), SZ_W);
      load_check(base, SZ_W);
      load_check(base + 14'd4, SZ_W);
    end
    wb_write(base + 14'd7, SZ_H, 32'h0000_a5c3);
    load_check(base + 14'd4, SZ_W);
    load_check(base + 14'd8, SZ_W);
    load_check(base + 14'd7, SZ_HU);
    // accesses that run off the last word continue at word 0.
    wb_write(14'h0000, SZ_W, 32'hcafe_f00d);
    wb_write(14'h3ffc, SZ_W, 32'h1357_9bdf);
    for (int off = 1; off < 4; off++) begin
      wb_write(14'h3ffc + ADDR_W'(off), SZ_W, $urandom);
      load_check(14'h3ffc + ADDR_W'(off), SZ_W);
      load_check(14'h0000, SZ_W);
    end
    wb_write(14'h3fff, SZ_H, 32'h0000_8e71);
    load_check(14'h3fff, SZ_H);
    load_check(14'h3ffc, SZ_W);
    load_check(14'h0000, SZ_W);
  endtask

  task automatic illegal_requests();
    logic [ADDR_W-1:0] base;
    logic [2:0]        reserved [3];
    base = 14'h0300;
    reserved[0] = 3'b011;
    reserved[1] = 3'b110;
    reserved[2] = 3'b111;
    wb_write(base, SZ_W, 32'hc001_d00d);
    for (int i = 0; i < 3; i++) begin
      err_check(1'b1, base, reserved[i]);
      load_check(base, SZ_W);
      err_check(1'b0, base, reserved[i]);
      load_check(base, SZ_W);
    end
    err_check(1'b1, base + 14'd1, SZ_BU);
    load_check(base, SZ_W);
    err_check(1'b1, base + 14'd1, SZ_HU);
    load_check(base, SZ_W);
  endtask

  function automatic logic [31:0] fill_pattern(input logic [WORD_IDX_W-1:0] idx);
    return {4'h9, idx, 4'h3, ~idx};
  endfunction

  task automatic random_traffic();
    logic [ADDR_W-1:0] a;
    logic [2:0]        f3;
    int unsigned       pick;
    // random addresses stay in words 0 to 63 and the last four words.
    for (int w = 0; w < 64; w++) begin
      wb_write(ADDR_W'(w * 4), SZ_W, fill_pattern(WORD_IDX_W'(w)));
    end
    for (int w = MEM_WORDS - 4; w < MEM_WORDS; w++) begin
      wb_write(ADDR_W'(w * 4), SZ_W, fill_pattern(WORD_IDX_W'(w)));
    end
    for (int n = 0; n < 200; n++) begin
      if ($urandom_range(0, 1) == 0) a = ADDR_W'($urandom_range(0, 251));
      else a = ADDR_W'(16368 + $urandom_range(0, 15));
      if ($urandom_range(0, 1) == 0) begin
        pick = $urandom_range(0, 2);
        f3 = 3'(pick);
        wb_write(a, f3, $urandom);
      end else begin
        pick = $urandom_range(0, 4);
        if (pick == 3) f3 = SZ_BU;
        else if (pick == 4) f3 = SZ_HU;
        else f3 = 3'(pick);
        load_check(a, f3);
      end
    end
  endtask

  initial begin
    i_reset  = 1'b0;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_adr = '0;
    i_wb_dat = '0;
    i_wb_tga = '0;
    void'($urandom(32'h6c79));
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b1;
    words_after_reset();
    subword_merge();
    load_extension();
    misaligned_access();
    illegal_requests();
    random_traffic();
    $display("test passed");
    $finish;
  end

endmodule
